/* Bender.yml */
package:
  name: aluTop

sources:
  # RTL in compile order
  - verilog/aluPkg.sv
  - verilog/aluControlLut.sv
  - verilog/aluBitSlice.sv
  - verilog/aluRippleCore.sv
  - verilog/aluTop.sv

  # Testbench
  - target: test
    files:
      - testbench/aluTbModel.sv
      - testbench/aluTopTb.sv

/* aluTop.f */
verilog/aluPkg.sv
verilog/aluControlLut.sv
verilog/aluBitSlice.sv
verilog/aluRippleCore.sv
verilog/aluTop.sv
testbench/aluTbModel.sv
testbench/aluTopTb.sv

/* testbench/aluTbModel.sv */
// Reference ALU model; flags always come from A+B, or A+~B+1 for SUB and SLT, on every command
package aluTbModel;
    import aluPkg::*;

    // Expected outputs for one operation, before the output register
    function automatic void computeAluOutputs(
        input  aluWord_t a,
        input  aluWord_t b,
        input  aluCmd_t  cmd,
        output aluWord_t res,
        output logic     carry,
        output logic     ovf,
        output logic     isZero
    );
        logic               subtract;
        aluWord_t           addend;
        logic [dataWidth:0] fullSum;

        // Only SUB and SLT subtract
        subtract = (cmd == cmdSub) || (cmd == cmdSlt);
        addend   = subtract ? ~b : b;
        fullSum  = {1'b0, a} + {1'b0, addend} + subtract;
        carry    = fullSum[dataWidth];

        // Same-sign addends with a sum of the other sign
        ovf = (a[dataWidth-1] == addend[dataWidth-1]) &&
              (fullSum[dataWidth-1] != a[dataWidth-1]);

        case (cmd)
            cmdAdd, cmdSub: begin
                res = fullSum[dataWidth-1:0];
            end
            cmdXor: begin
                res = a ^ b;
            end
            cmdSlt: begin
                res = ($signed(a) < $signed(b)) ? aluWord_t'(1) : '0;
            end
            cmdAnd: begin
                res = a & b;
            end
            cmdNand: begin
                res = ~(a & b);
            end
            cmdNor: begin
                res = ~(a | b);
            end
            default: begin
                res = a | b;
            end
        endcase

        isZero = (res == '0);
    endfunction

endpackage

/* testbench/aluTopTb.sv */
// Self-checking testbench for aluTop; assumes exactly 1 cycle of latency and no handshake
module aluTopTb;
    timeunit 1ns;
    timeprecision 1ps;

    import aluPkg::*;
    import aluTbModel::*;

    localparam int clkPeriod    = 10;
    localparam int resetCycles  = 3;
    localparam int arithOps     = 200;
    localparam int logicOps     = 200;
    localparam int sltOps       = 150;
    localparam int mixedOps     = 300;
    localparam int directedOps  = 3 + 8;
    localparam int totalOps     = arithOps + logicOps + sltOps + mixedOps + directedOps;
    localparam int timeoutCycles = totalOps + resetCycles + 50;

    logic     clk = 1'b0;
    logic     rst;
    aluWord_t operandA;
    aluWord_t operandB;
    aluCmd_t  command;
    aluWord_t result;
    logic     carryout;
    logic     overflow;
    logic     zero;

    // Expected outputs, one entry per issued operation
    aluWord_t expResultQ[$];
    logic     expCarryQ[$];
    logic     expOverflowQ[$];
    logic     expZeroQ[$];
    aluCmd_t  cmdQ[$];

    int testErrors  = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    aluTop dut0 (
        .clk      (clk),
        .rst      (rst),
        .operandA (operandA),
        .operandB (operandB),
        .command  (command),
        .result   (result),
        .carryout (carryout),
        .overflow (overflow),
        .zero     (zero)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Mostly uniform, with signed and unsigned corners mixed in
    function automatic aluWord_t randomWord();
        aluWord_t corners[5];
        corners = '{32'h0, 32'h1, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
        if ($urandom_range(7, 0) == 0) begin
            return corners[$urandom_range(4, 0)];
        end
        return $urandom();
    endfunction

    task automatic checkOutputs();
        aluWord_t expRes;
        logic     expC;
        logic     expV;
        logic     expZ;
        aluCmd_t  cmd;
        expRes = expResultQ.pop_front();
        expC   = expCarryQ.pop_front();
        expV   = expOverflowQ.pop_front();
        expZ   = expZeroQ.pop_front();
        cmd    = cmdQ.pop_front();
        assert (result === expRes) else begin
            $display("Error: result %h, expected %h (command %h)", result, expRes, cmd);
            testErrors++;
        end
        assert (carryout === expC) else begin
            $display("Error: carryout %h, expected %h (command %h)", carryout, expC, cmd);
            testErrors++;
        end
        assert (overflow === expV) else begin
            $display("Error: overflow %h, expected %h (command %h)", overflow, expV, cmd);
            testErrors++;
        end
        assert (zero === expZ) else begin
            $display("Error: zero %h, expected %h (command %h)", zero, expZ, cmd);
            testErrors++;
        end
    endtask

    // Drive one op, then check it right after the edge that samples it
    task automatic runOp(input aluWord_t a, input aluWord_t b, input aluCmd_t cmd);
        aluWord_t expRes;
        logic     expC;
        logic     expV;
        logic     expZ;
        operandA = a;
        operandB = b;
        command  = cmd;
        computeAluOutputs(a, b, cmd, expRes, expC, expV, expZ);
        expResultQ.push_back(expRes);
        expCarryQ.push_back(expC);
        expOverflowQ.push_back(expV);
        expZeroQ.push_back(expZ);
        cmdQ.push_back(cmd);
        @(posedge clk);
        #1;
        checkOutputs();
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("Test %s: ok", name);
            testsPassed++;
        end else begin
            $display("Test %s: %0d mismatches", name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    initial begin
        aluCmd_t logicCmds[5];
        aluWord_t a;
        logicCmds = '{cmdXor, cmdAnd, cmdNand, cmdNor, cmdOr};
        void'($urandom(15937));
        rst      = 1'b1;
        operandA = '0;
        operandB = '0;
        command  = cmdAdd;

        // Inputs keep changing during reset, outputs must stay cleared
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            operandA = randomWord();
            operandB = randomWord();
            command  = aluCmd_t'($urandom_range(7, 0));
        end
        assert (result === '0) else begin
            $display("Error: result %h after reset, expected %h", result, 32'h0);
            testErrors++;
        end
        assert ({carryout, overflow, zero} === 3'b000) else begin
            $display("Error: carryout/overflow/zero %h after reset, expected %h",
                     {carryout, overflow, zero}, 3'b000);
            testErrors++;
        end
        rst = 1'b0;
        finishTest("reset");

        runOp(32'h7FFF_FFFF, 32'h1, cmdAdd);
        runOp(32'h8000_0000, 32'h1, cmdSub);
        // 0 - 0 carries out of the inverted add
        runOp(32'h0, 32'h0, cmdSub);
        for (int i = 0; i < arithOps; i++) begin
            runOp(randomWord(), randomWord(), ($urandom_range(1, 0) == 0) ? cmdAdd : cmdSub);
        end
        finishTest("arithmetic");

        for (int i = 0; i < logicOps; i++) begin
            runOp(randomWord(), randomWord(), logicCmds[$urandom_range(4, 0)]);
        end
        finishTest("logic");

        runOp(32'h8000_0000, 32'h7FFF_FFFF, cmdSlt);
        runOp(32'h7FFF_FFFF, 32'h8000_0000, cmdSlt);
        runOp(32'h8000_0000, 32'h8000_0000, cmdSlt);
        runOp(32'hFFFF_FFFF, 32'h0, cmdSlt);
        runOp(32'h0, 32'hFFFF_FFFF, cmdSlt);
        runOp(32'h5, 32'h5, cmdSlt);
        runOp(32'h7FFF_FFFF, 32'hFFFF_FFFF, cmdSlt);
        runOp(32'h8000_0000, 32'h1, cmdSlt);
        for (int i = 0; i < sltOps; i++) begin
            runOp(randomWord(), randomWord(), cmdSlt);
        end
        finishTest("slt");

        // One op per cycle, with self-cancelling ops now and then
        for (int i = 0; i < mixedOps; i++) begin
            a = randomWord();
            if (i % 10 == 0) begin
                runOp(a, a, cmdXor);
            end else if (i % 10 == 5) begin
                runOp(a, a, cmdSub);
            end else begin
                runOp(a, randomWord(), aluCmd_t'($urandom_range(7, 0)));
            end
        end
        finishTest("zero flag and throughput");

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* verilog/aluBitSlice.sv */
// One ALU bit, no gate delays modelled; logic ops use raw b, only the adder sees inverted b
module aluBitSlice (
    input  logic            a,
    input  logic            b,
    input  logic            carryIn,
    input  logic            invertB,
    input  logic            andOrSel,
    input  aluPkg::muxSel_t muxIndex,
    output logic            result,
    output logic            carryOut
);
    import aluPkg::*;

    logic bEff;
    logic sum;
    logic aXorB;
    logic nandAnd;
    logic norOr;

    // B inverter for subtraction
    assign bEff = b ^ invertB;

    // Full adder
    assign sum      = a ^ bEff ^ carryIn;
    assign carryOut = (a & bEff) | (carryIn & (a ^ bEff));

    assign aXorB = a ^ b;

    // andOrSel picks the true form, else the inverted one
    assign nandAnd = andOrSel ? (a & b) : ~(a & b);
    assign norOr   = andOrSel ? (a | b) : ~(a | b);

    // Output select
    always_comb begin
        case (muxIndex)
            selAddSub: begin
                result = sum;
            end
            selXor: begin
                result = aXorB;
            end
            selNandAnd: begin
                result = nandAnd;
            end
            selNorOr: begin
                result = norOr;
            end
            selNone: begin
                result = 1'b0;
            end
            default: begin
                result = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/aluControlLut.sv */
// Pure combinational command decode; all eight 3-bit codes are legal, there is no invalid command
module aluControlLut (
    input  aluPkg::aluCmd_t command,
    output aluPkg::muxSel_t muxIndex,
    output logic            invertB,
    output logic            andOrSel,
    output logic            sltEnable
);
    import aluPkg::*;

    always_comb begin
        // Defaults match ADD
        muxIndex  = selAddSub;
        invertB   = 1'b0;
        andOrSel  = 1'b0;
        sltEnable = 1'b0;
        case (command)
            cmdAdd: begin
                muxIndex = selAddSub;
            end
            cmdSub: begin
                muxIndex = selAddSub;
                invertB  = 1'b1;
            end
            cmdXor: begin
                muxIndex = selXor;
            end
            cmdSlt: begin
                // Subtract for the compare, slices themselves output 0
                muxIndex  = selNone;
                invertB   = 1'b1;
                sltEnable = 1'b1;
            end
            cmdNand: begin
                muxIndex = selNandAnd;
            end
            cmdAnd: begin
                muxIndex = selNandAnd;
                andOrSel = 1'b1;
            end
            cmdNor: begin
                muxIndex = selNorOr;
            end
            cmdOr: begin
                muxIndex = selNorOr;
                andOrSel = 1'b1;
            end
            default: begin
                muxIndex = selNone;
            end
        endcase
    end

    // Slices only decode up to selNone
    legalMuxIndex: assert final (
        $isunknown(command) || muxIndex <= selNone
    ) else $error("aluControlLut: bad controls %h for command %h", muxIndex, command);

endmodule

/* verilog/aluPkg.sv */
// Shared ALU widths and encodings; command codes follow the teaching processor decode, 3 bits only
package aluPkg;

    // Operand and result width
    localparam int dataWidth = 32;

    // Operand and result word
    typedef logic [dataWidth-1:0] aluWord_t;

    // ALU command as issued by the processor decoder
    typedef logic [2:0] aluCmd_t;

    // Index into the per-bit output mux
    typedef logic [2:0] muxSel_t;

    // Command codes
    localparam aluCmd_t cmdAdd  = 3'd0;
    localparam aluCmd_t cmdSub  = 3'd1;
    localparam aluCmd_t cmdXor  = 3'd2;
    localparam aluCmd_t cmdSlt  = 3'd3;
    localparam aluCmd_t cmdAnd  = 3'd4;
    localparam aluCmd_t cmdNand = 3'd5;
    localparam aluCmd_t cmdNor  = 3'd6;
    localparam aluCmd_t cmdOr   = 3'd7;

    // Slice mux inputs
    localparam muxSel_t selAddSub  = 3'd0;
    localparam muxSel_t selXor     = 3'd1;
    localparam muxSel_t selNandAnd = 3'd2;
    localparam muxSel_t selNorOr   = 3'd3;
    // Slices drive 0, the core fills in bit 0 for SLT
    localparam muxSel_t selNone    = 3'd4;

endpackage

/* verilog/aluRippleCore.sv */
// Combinational ripple-carry datapath; long carry chain, flags are reported for every command
module aluRippleCore (
    input  aluPkg::aluWord_t operandA,
    input  aluPkg::aluWord_t operandB,
    input  aluPkg::muxSel_t  muxIndex,
    input  logic             invertB,
    input  logic             andOrSel,
    input  logic             sltEnable,
    output aluPkg::aluWord_t aluResult,
    output logic             aluCarryOut,
    output logic             aluOverflow
);
    import aluPkg::*;

    // carry[i] is the carry into bit i, carry[dataWidth] the final carry out
    logic [dataWidth:0] carry;
    aluWord_t           sliceResult;
    logic               sumSign;
    logic               lessThan;

    // Plus one of the two's complement
    assign carry[0] = invertB;

    genvar i;
    generate
        for (i = 0; i < dataWidth; i++) begin : gSlice
            aluBitSlice bitSlice (
                .a        (operandA[i]),
                .b        (operandB[i]),
                .carryIn  (carry[i]),
                .invertB  (invertB),
                .andOrSel (andOrSel),
                .muxIndex (muxIndex),
                .result   (sliceResult[i]),
                .carryOut (carry[i+1])
            );
        end
    endgenerate

    assign aluCarryOut = carry[dataWidth];

    // Signed overflow from the carries into and out of the MSB
    assign aluOverflow = carry[dataWidth] ^ carry[dataWidth-1];

    // Sum MSB rebuilt here; the slice mux hides it while SLT runs
    assign sumSign = operandA[dataWidth-1] ^ operandB[dataWidth-1] ^ invertB
                     ^ carry[dataWidth-1];

    // Signed A < B, corrected for overflow
    assign lessThan = sumSign ^ aluOverflow;

    // Compare bit goes into bit 0 only
    assign aluResult = {sliceResult[dataWidth-1:1], sltEnable ? lessThan : sliceResult[0]};

    // Upper bits depend on the slices decoding selNone to 0
    sltUpperZero: assert final (
        sltEnable !== 1'b1 || aluResult[dataWidth-1:1] == '0
    ) else $error("aluRippleCore: SLT result %h has upper bits set", aluResult);

endmodule

/* verilog/aluTop.sv */
// Registered ALU, 1-cycle latency, one operation per clock; no handshake, inputs sampled every edge
module aluTop (
    input  logic             clk,
    input  logic             rst,
    input  aluPkg::aluWord_t operandA,
    input  aluPkg::aluWord_t operandB,
    input  aluPkg::aluCmd_t  command,
    output aluPkg::aluWord_t result,
    output logic             carryout,
    output logic             overflow,
    output logic             zero
);
    import aluPkg::*;

    // Decoded slice controls
    muxSel_t muxIndex;
    logic    invertB;
    logic    andOrSel;
    logic    sltEnable;

    // Combinational core outputs
    aluWord_t coreResult;
    logic     coreCarryOut;
    logic     coreOverflow;
    logic     coreZero;

    aluControlLut controlLut (
        .command   (command),
        .muxIndex  (muxIndex),
        .invertB   (invertB),
        .andOrSel  (andOrSel),
        .sltEnable (sltEnable)
    );

    aluRippleCore rippleCore (
        .operandA    (operandA),
        .operandB    (operandB),
        .muxIndex    (muxIndex),
        .invertB     (invertB),
        .andOrSel    (andOrSel),
        .sltEnable   (sltEnable),
        .aluResult   (coreResult),
        .aluCarryOut (coreCarryOut),
        .aluOverflow (coreOverflow)
    );

    // Zero taken before the register so it lines up with result
    assign coreZero = (coreResult == '0);

    // Output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            // zero is cleared too, even though result reads 0
            result   <= '0;
            carryout <= 1'b0;
            overflow <= 1'b0;
            zero     <= 1'b0;
        end else begin
            result   <= coreResult;
            carryout <= coreCarryOut;
            overflow <= coreOverflow;
            zero     <= coreZero;
        end
    end

    // Registered zero must agree with the registered result
    zeroMatchesResult: assert property (
        @(posedge clk) zero |-> (result == '0)
    ) else $error("aluTop: zero set with result %h", result);

    // One cycle after a sampled op the outputs are fully known
    outputsKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown({operandA, operandB, command}) |=>
            !$isunknown({result, carryout, overflow, zero})
    ) else $error("aluTop: unknown output, result %h", result);

endmodule
